// File: sources.f
+incdir+.
hc_pkg.sv
adc_capture.sv
hybrid_law.sv
dead_time.sv
gate_supervisor.sv
hybrid_control_top.sv
tb_clock_gen.sv
hybrid_control_asserts.sv
tb_hybrid_control.sv

// File: Makefile
# Verilator build and run of the hybrid control testbench

VERILATOR ?= verilator
TOP       ?= tb_hybrid_control
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation FAIL, see $(LOG)"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
		echo "simulation FAIL, no result in $(LOG)"; exit 1; \
	else \
		echo "simulation PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_hybrid_control.sv
// directed testbench for the hybrid control path: start-up, switching law, dead time, disable
`timescale 1ns/1ps
`include "hc_params.svh"

module tb_hybrid_control;

   localparam int AW    = `HC_ADC_W;
   localparam int SW    = `HC_SET_W;
   localparam int PHI   = 20;
   localparam int DELTA = 30;
   // vC switching threshold in ADC counts
   localparam int VTH   = PHI * `HC_PHI_SCALE;

   logic                 ada_dco;
   logic                 rst;
   logic signed [AW-1:0] ada_data;
   logic signed [AW-1:0] adb_data;
   logic                 ada_or;
   logic                 adb_or;
   logic                 enable;
   logic [SW-1:0]        phi;
   logic [SW-1:0]        delta;
   logic [1:0]           dt_sel;
   logic [3:0]           q;
   hc_pkg::sigma_e       sigma;

   int     errors;
   int     tests;
   int     bad_tests;
   integer seed;

   tb_clock_gen u_clk (.o_clk (ada_dco), .o_reset (rst));

   hybrid_control_top u_dut (
      .ADA_DCO    (ada_dco),
      .i_reset    (rst),
      .i_ada_data (ada_data),
      .i_adb_data (adb_data),
      .i_ada_or   (ada_or),
      .i_adb_or   (adb_or),
      .i_enable   (enable),
      .i_phi      (phi),
      .i_delta    (delta),
      .i_dt_sel   (dt_sel),
      .o_q        (q),
      .o_sigma    (sigma)
   );

   bind hybrid_control_top hybrid_control_asserts u_asserts (
      .ADA_DCO   (ADA_DCO),
      .i_reset   (i_reset),
      .i_enable  (i_enable),
      .i_q       (o_q),
      .i_dt_gate (dt_gate),
      .i_sigma   (o_sigma),
      .i_state   (u_sup.state)
   );

   // ========================================
   // helpers
   // ========================================

   task automatic check(input string msg, input int got, input int exp);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
         errors++;
      end
   endtask

   // inputs move 1 ns after the edge, outputs are settled there too
   task automatic step();
      @(posedge ada_dco);
      #1;
   endtask

   // front end inverts, so the pins carry the negated tank values
   task automatic drive_tank(input int vc, input int ic);
      ada_data = AW'(-vc);
      adb_data = AW'(-ic);
   endtask

   function automatic int rand_amp(input int mask);
      return $random(seed) & mask;
   endfunction

   // step until o_q shows pat, give up after limit cycles
   task automatic wait_q(input logic [3:0] pat, input int limit, output int n);
      n = 0;
      while (q != pat && n < limit) begin
         step();
         n++;
      end
      if (q != pat) begin
         $display("timeout at %0t ns: o_q did not reach %b in %0d cycles", $time, pat, limit);
         errors++;
      end
   endtask

   // sample held 4 cycles, long enough for a switch to show
   task automatic hold_tank(input int vc, input int ic, input hc_pkg::sigma_e exp_sigma,
                            input logic [3:0] exp_q);
      drive_tank(vc, ic);
      repeat (4) begin
         step();
         check("sigma held", int'(sigma), int'(exp_sigma));
         check("o_q held", int'(q), int'(exp_q));
      end
      drive_tank(0, 0);
   endtask

   // cycles to turn-off, then length of the all-off gap
   task automatic switch_and_measure(input int vc, input int ic, output int t_off,
                                     output int gap);
      drive_tank(vc, ic);
      wait_q(4'b0000, 10, t_off);
      gap = 0;
      while (q == 4'b0000 && gap < 40) begin
         step();
         gap++;
      end
      drive_tank(0, 0);
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("[%0t] test %s: clean", $time, name);
      end else begin
         bad_tests++;
         $display("[%0t] test %s: %0d errors", $time, name, errors - errs_before);
      end
   endtask

   // ========================================
   // tests
   // ========================================

   task automatic test_idle();
      repeat (20) begin
         step();
         check("idle o_q", int'(q), 0);
         check("idle sigma", int'(sigma), int'(hc_pkg::SIGMA_POS));
      end
      // law held, a switching sample changes nothing
      hold_tank(VTH + 200, -(DELTA + 20), hc_pkg::SIGMA_POS, 4'b0000);
   endtask

   // boot run of 1100, preset state length, 1001 after boot
   task automatic start_up();
      int   n_boot;
      int   n_pre;
      logic seen_boot;
      n_boot    = 0;
      n_pre     = 0;
      seen_boot = 1'b0;
      enable    = 1'b1;
      for (int i = 0; i < 80; i++) begin
         step();
         if (u_dut.u_sup.state == hc_pkg::SUP_PRESET) begin
            n_pre++;
         end
         if (q == 4'b1100) begin
            n_boot++;
            seen_boot = 1'b1;
         end else if (seen_boot) begin
            check("preset and run o_q", int'(q), 4'b1001);
         end else begin
            check("o_q before boot", int'(q), 0);
         end
      end
      check("boot cycles", n_boot, `HC_BOOT_CYCLES);
      check("preset cycles", n_pre, `HC_PRESET_CYCLES);
   endtask

   task automatic test_switching();
      int vamp;
      int iamp;
      int t_off;
      int gap;
      vamp = VTH + rand_amp(1023);
      iamp = DELTA + rand_amp(255);
      // one condition alone never switches
      hold_tank(vamp, 0, hc_pkg::SIGMA_POS, 4'b1001);
      hold_tank(0, -iamp, hc_pkg::SIGMA_POS, 4'b1001);
      switch_and_measure(vamp, -iamp, t_off, gap);
      check("turn-off latency", t_off, 4);
      check("sigma after pos to neg", int'(sigma), int'(hc_pkg::SIGMA_NEG));
      check("o_q after pos to neg", int'(q), 4'b0110);
      hold_tank(-vamp, 0, hc_pkg::SIGMA_NEG, 4'b0110);
      hold_tank(0, iamp, hc_pkg::SIGMA_NEG, 4'b0110);
      switch_and_measure(-vamp, iamp, t_off, gap);
      check("turn-off latency", t_off, 4);
      check("sigma after neg to pos", int'(sigma), int'(hc_pkg::SIGMA_POS));
      check("o_q after neg to pos", int'(q), 4'b1001);
   endtask

   task automatic test_dead_time();
      int         order[4];
      int         dt_tab[4];
      int         t_off;
      int         gap;
      logic [3:0] exp_q;
      // longest delay first, a shorter code keeps gates that are on
      order  = '{0, 3, 2, 1};
      dt_tab = '{`HC_DT0, `HC_DT1, `HC_DT2, `HC_DT3};
      foreach (order[i]) begin
         dt_sel = 2'(order[i]);
         step();
         if (sigma == hc_pkg::SIGMA_POS) begin
            exp_q = 4'b0110;
            switch_and_measure(VTH + 50, -(DELTA + 5), t_off, gap);
         end else begin
            exp_q = 4'b1001;
            switch_and_measure(-(VTH + 50), DELTA + 5, t_off, gap);
         end
         check("turn-off latency", t_off, 4);
         check("dead-time gap", gap, dt_tab[order[i]]);
         check("o_q after gap", int'(q), int'(exp_q));
      end
   endtask

   task automatic test_out_of_range();
      ada_or = 1'b1;
      hold_tank(VTH + 300, -(DELTA + 30), hc_pkg::SIGMA_POS, 4'b1001);
      ada_or = 1'b0;
      adb_or = 1'b1;
      hold_tank(VTH + 300, -(DELTA + 30), hc_pkg::SIGMA_POS, 4'b1001);
      adb_or = 1'b0;
   endtask

   task automatic test_disable();
      int n;
      enable = 1'b0;
      wait_q(4'b0000, 2, n);
      hold_tank(0, 0, hc_pkg::SIGMA_POS, 4'b0000);
      // full sequence again
      start_up();
   endtask

   // ========================================
   // main sequence
   // ========================================

   initial begin
      int e0;
      int n;
      seed      = 32'h7c1ee3c4;
      errors    = 0;
      tests     = 0;
      bad_tests = 0;
      ada_data  = '0;
      adb_data  = '0;
      ada_or    = 1'b0;
      adb_or    = 1'b0;
      enable    = 1'b0;
      phi       = SW'(PHI);
      delta     = SW'(DELTA);
      dt_sel    = 2'd0;

      step();
      n = 0;
      while (rst && n < 40) begin
         step();
         n++;
      end
      if (rst) begin
         $display("reset still asserted after %0d cycles", n);
         errors++;
      end

      e0 = errors;
      test_idle();
      report_test("1 idle after reset", e0);
      e0 = errors;
      start_up();
      // just inside both thresholds, no switch
      hold_tank(VTH - 1, -(DELTA - 1), hc_pkg::SIGMA_POS, 4'b1001);
      report_test("2 start-up sequence", e0);
      e0 = errors;
      test_switching();
      report_test("3 switching law", e0);
      e0 = errors;
      test_dead_time();
      report_test("4 dead-time table", e0);
      e0 = errors;
      test_out_of_range();
      report_test("5 out-of-range rejection", e0);
      e0 = errors;
      test_disable();
      report_test("6 disable and restart", e0);

      n = u_dut.u_asserts.fail_count;
      errors += n;
      $display("summary: %0d tests, %0d with errors, %0d errors, %0d assertion failures",
               tests, bad_tests, errors, n);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: hybrid_control_asserts.sv
// hybrid control assertions: leg shoot-through, blanking while disabled, law hold before run
`timescale 1ns/1ps

module hybrid_control_asserts (
   input  logic                ADA_DCO,
   input  logic                i_reset,
   input  logic                i_enable,
   input  logic [3:0]          i_q,
   input  hc_pkg::gate_t       i_dt_gate,
   input  hc_pkg::sigma_e      i_sigma,
   input  hc_pkg::sup_state_e  i_state
);

   // failure tally per property
   int n_shoot;
   int n_off;
   int n_hold;
   int fail_count;

   initial begin
      n_shoot = 0;
      n_off   = 0;
      n_hold  = 0;
   end

   assign fail_count = n_shoot + n_off + n_hold;

   // ========================================
   // bridge safety
   // ========================================

   // leg 1 is bits 0 and 2, leg 2 is bits 1 and 3
   // dead-time output ahead of the blanking, and the pins
   a_no_shoot: assert property (
      @(posedge ADA_DCO) disable iff (i_reset)
      !((i_dt_gate.m1 && i_dt_gate.m3) || (i_dt_gate.m2 && i_dt_gate.m4)) &&
      !((i_q[0] && i_q[2]) || (i_q[1] && i_q[3])))
   else begin
      n_shoot++;
      $error("both devices of one leg on, o_q=%b dt_gate=%b", i_q, i_dt_gate);
   end

   // enable low for two edges, every gate off
   a_off_when_disabled: assert property (
      @(posedge ADA_DCO) disable iff (i_reset)
      (!i_enable && !$past(i_enable)) |-> (i_q == 4'b0000))
   else begin
      n_off++;
      $error("gates still on with enable low, o_q=%b", i_q);
   end

   // ========================================
   // start-up
   // ========================================

   // law frozen in idle, boot and preset
   // sigma parked in pos one edge later
   a_hold_until_run: assert property (
      @(posedge ADA_DCO) disable iff (i_reset)
      (i_state != hc_pkg::SUP_RUN) |=> (i_sigma == hc_pkg::SIGMA_POS))
   else begin
      n_hold++;
      $error("sigma moved outside run, sigma=%0d", i_sigma);
   end

endmodule

// File: tb_clock_gen.sv
// testbench clock and reset source: 8 ns ADA_DCO clock, reset held for 16 cycles
`timescale 1ns/1ps

module tb_clock_gen (
   output logic o_clk,
   output logic o_reset
);

   // 125 MHz, same rate as the tank ADC data clock
   initial begin
      o_clk = 1'b0;
      forever #4 o_clk = ~o_clk;
   end

   // synchronous reset, released just after an edge
   initial begin
      o_reset = 1'b1;
      repeat (16) @(posedge o_clk);
      #1 o_reset = 1'b0;
   end

endmodule

// File: hybrid_control_top.sv
// hybrid control top: adc capture, switching law, dead time and gate supervisor in a chain
`timescale 1ns/1ps
`include "hc_params.svh"

module hybrid_control_top (
   input  logic                         ADA_DCO,
   input  logic                         i_reset,
   // tank converters
   input  logic signed [`HC_ADC_W-1:0]  i_ada_data,
   input  logic signed [`HC_ADC_W-1:0]  i_adb_data,
   input  logic                         i_ada_or,
   input  logic                         i_adb_or,
   // control
   input  logic                         i_enable,
   input  logic [`HC_SET_W-1:0]         i_phi,
   input  logic [`HC_SET_W-1:0]         i_delta,
   input  logic [1:0]                   i_dt_sel,
   // bridge, bit 0 is m1
   output logic [3:0]                   o_q,
   output hc_pkg::sigma_e               o_sigma
);

   hc_pkg::tank_sample_t sample;
   hc_pkg::gate_t        law_gate;
   hc_pkg::gate_t        dt_gate;
   logic                 law_hold;

   // ========================================
   // pipeline, one edge per stage
   // ========================================

   // stage 1, sample capture
   adc_capture u_capture (
      .ADA_DCO    (ADA_DCO),
      .i_reset    (i_reset),
      .i_ada_data (i_ada_data),
      .i_adb_data (i_adb_data),
      .i_ada_or   (i_ada_or),
      .i_adb_or   (i_adb_or),
      .o_sample   (sample)
   );

   // stage 2, sigma from tank state
   hybrid_law u_law (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_hold   (law_hold),
      .i_sample (sample),
      .i_phi    (i_phi),
      .i_delta  (i_delta),
      .o_gate   (law_gate),
      .o_sigma  (o_sigma)
   );

   // stage 3, turn-on delay
   dead_time u_dead (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_gate   (law_gate),
      .i_dt_sel (i_dt_sel),
      .o_gate   (dt_gate)
   );

   // stage 4, start-up and protection
   // hold goes back to the law
   gate_supervisor u_sup (
      .ADA_DCO    (ADA_DCO),
      .i_reset    (i_reset),
      .i_enable   (i_enable),
      .i_gate     (dt_gate),
      .o_q        (o_q),
      .o_law_hold (law_hold)
   );

endmodule

// File: gate_supervisor.sv
// gate supervisor: enable, bootstrap, preset and run sequence with shoot-through blanking
`timescale 1ns/1ps
`include "hc_params.svh"

module gate_supervisor (
   input  logic            ADA_DCO,
   input  logic            i_reset,
   input  logic            i_enable,
   input  hc_pkg::gate_t   i_gate,
   output logic [3:0]      o_q,
   output logic            o_law_hold
);

   // counter sized for the longer start-up phase
   localparam int PH_MAX = (`HC_BOOT_CYCLES > `HC_PRESET_CYCLES) ?
                           `HC_BOOT_CYCLES : `HC_PRESET_CYCLES;
   localparam int CW     = $clog2(PH_MAX + 1);

   // fixed start-up patterns, bit 0 is m1
   // boot drives both low sides m3 + m4
   localparam logic [3:0] Q_BOOT   = 4'b1100;
   // preset is the sigma pos diagonal m1 + m4
   localparam logic [3:0] Q_PRESET = 4'b1001;

   hc_pkg::sup_state_e state;
   logic [CW-1:0]      ph_cnt;
   logic [3:0]         gate_in;
   logic               shoot;

   assign gate_in = i_gate;

   // both devices of one leg on
   assign shoot = (gate_in[0] & gate_in[2]) | (gate_in[1] & gate_in[3]);

   // ========================================
   // start-up FSM
   // ========================================

   always_ff @(posedge ADA_DCO) begin
      if (i_reset || !i_enable) begin
         state  <= hc_pkg::SUP_IDLE;
         ph_cnt <= '0;
      end else begin
         unique case (state)
            hc_pkg::SUP_IDLE: begin
               // enable seen, boot starts next cycle
               state  <= hc_pkg::SUP_BOOT;
               ph_cnt <= '0;
            end
            hc_pkg::SUP_BOOT: begin
               if (ph_cnt == CW'(`HC_BOOT_CYCLES - 1)) begin
                  state  <= hc_pkg::SUP_PRESET;
                  ph_cnt <= '0;
               end else begin
                  ph_cnt <= ph_cnt + 1'b1;
               end
            end
            hc_pkg::SUP_PRESET: begin
               if (ph_cnt == CW'(`HC_PRESET_CYCLES - 1)) begin
                  state  <= hc_pkg::SUP_RUN;
                  ph_cnt <= '0;
               end else begin
                  ph_cnt <= ph_cnt + 1'b1;
               end
            end
            default: begin
               // run until enable drops
               state <= hc_pkg::SUP_RUN;
            end
         endcase
      end
   end

   // law free only in run
   assign o_law_hold = (state != hc_pkg::SUP_RUN);

   // ========================================
   // output register
   // ========================================

   always_ff @(posedge ADA_DCO) begin
      if (i_reset || !i_enable) begin
         o_q <= 4'b0000;
      end else begin
         unique case (state)
            hc_pkg::SUP_BOOT:   o_q <= Q_BOOT;
            hc_pkg::SUP_PRESET: o_q <= Q_PRESET;
            // blank every gate on a shoot-through pattern
            hc_pkg::SUP_RUN:    o_q <= shoot ? 4'b0000 : gate_in;
            default:            o_q <= 4'b0000;
         endcase
      end
   end

endmodule

// File: dead_time.sv
// dead-time insertion: delays every gate turn-on by the selected count, turn-off passes at once
`timescale 1ns/1ps
`include "hc_params.svh"

module dead_time (
   input  logic            ADA_DCO,
   input  logic            i_reset,
   input  hc_pkg::gate_t   i_gate,
   input  logic [1:0]      i_dt_sel,
   output hc_pkg::gate_t   o_gate
);

   localparam int DW = `HC_DT_MAX_W;

   logic [3:0]    gate_in;
   logic [3:0]    gate_out;
   logic [DW-1:0] dt_cycles;

   assign gate_in = i_gate;

   // ========================================
   // dead-time table
   // ========================================

   always_comb begin
      unique case (i_dt_sel)
         2'd0:    dt_cycles = DW'(`HC_DT0);
         2'd1:    dt_cycles = DW'(`HC_DT1);
         2'd2:    dt_cycles = DW'(`HC_DT2);
         default: dt_cycles = DW'(`HC_DT3);
      endcase
   end

   // ========================================
   // one delay counter per gate
   // ========================================

   for (genvar g = 0; g < 4; g++) begin : g_gate
      logic [DW-1:0] cnt;
      logic          q;

      always_ff @(posedge ADA_DCO) begin
         if (i_reset) begin
            cnt <= '0;
            q   <= 1'b0;
         end else if (!gate_in[g]) begin
            // input low restarts the delay
            // output follows the fall next edge
            cnt <= '0;
            q   <= 1'b0;
         end else begin
            // saturate at the table value
            if (cnt < dt_cycles) begin
               cnt <= cnt + 1'b1;
            end
            // >= so a smaller code picked mid-run still fires
            q <= (cnt >= dt_cycles);
         end
      end

      assign gate_out[g] = q;
   end

   assign o_gate = hc_pkg::gate_t'(gate_out);

endmodule

// File: hybrid_law.sv
// hybrid switching law: sets sigma from tank-state thresholds and maps it to a bridge pattern
`timescale 1ns/1ps
`include "hc_params.svh"

module hybrid_law (
   input  logic                      ADA_DCO,
   input  logic                      i_reset,
   input  logic                      i_hold,
   input  hc_pkg::tank_sample_t      i_sample,
   input  logic [`HC_SET_W-1:0]      i_phi,
   input  logic [`HC_SET_W-1:0]      i_delta,
   output hc_pkg::gate_t             o_gate,
   output hc_pkg::sigma_e            o_sigma
);

   // threshold math width, phi*scale overflows the ADC word
   localparam int TW = `HC_ADC_W + 4;

   hc_pkg::sigma_e       sigma_q;
   hc_pkg::sigma_e       sigma_nxt;

   logic signed [TW-1:0] vc_ext;
   logic signed [TW-1:0] ic_ext;
   logic signed [TW-1:0] phi_th;
   logic signed [TW-1:0] delta_th;
   logic                 to_pos;
   logic                 to_neg;

   // bridge pattern for a given sigma
   function automatic hc_pkg::gate_t gate_of(input hc_pkg::sigma_e s);
      hc_pkg::gate_t g;
      g = '0;
      if (s == hc_pkg::SIGMA_POS) begin
         // diagonal m1 + m4
         g.m1 = 1'b1;
         g.m4 = 1'b1;
      end else begin
         // diagonal m2 + m3
         g.m2 = 1'b1;
         g.m3 = 1'b1;
      end
      return g;
   endfunction

   // ========================================
   // thresholds
   // ========================================

   // sign extend the tank samples
   assign vc_ext = $signed(i_sample.vc);
   assign ic_ext = $signed(i_sample.ic);

   // setpoints are unsigned, zero extend
   assign phi_th   = $signed(TW'(i_phi) * TW'(`HC_PHI_SCALE));
   assign delta_th = $signed(TW'(i_delta));

   // neg -> pos: current positive past zvs margin, voltage low enough
   assign to_pos = (ic_ext >= delta_th) && (vc_ext <= -phi_th);
   // pos -> neg: mirror image of the rule above
   assign to_neg = (ic_ext <= -delta_th) && (vc_ext >= phi_th);

   // ========================================
   // sigma FSM
   // ========================================

   always_comb begin
      sigma_nxt = sigma_q;
      if (i_hold) begin
         // start-up or disabled, park in pos
         sigma_nxt = hc_pkg::SIGMA_POS;
      end else if (i_sample.valid) begin
         unique case (sigma_q)
            hc_pkg::SIGMA_NEG: if (to_pos) sigma_nxt = hc_pkg::SIGMA_POS;
            hc_pkg::SIGMA_POS: if (to_neg) sigma_nxt = hc_pkg::SIGMA_NEG;
            default:           sigma_nxt = hc_pkg::SIGMA_POS;
         endcase
      end
   end

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         sigma_q <= hc_pkg::SIGMA_POS;
         o_gate  <= gate_of(hc_pkg::SIGMA_POS);
      end else begin
         sigma_q <= sigma_nxt;
         // pattern updates on the same edge as sigma
         o_gate  <= gate_of(sigma_nxt);
      end
   end

   assign o_sigma = sigma_q;

endmodule

// File: adc_capture.sv
// tank ADC capture: registers vC and iC, undoes the front-end inversion, flags clipped samples
`timescale 1ns/1ps
`include "hc_params.svh"

module adc_capture (
   input  logic                         ADA_DCO,
   input  logic                         i_reset,
   input  logic signed [`HC_ADC_W-1:0]  i_ada_data,
   input  logic signed [`HC_ADC_W-1:0]  i_adb_data,
   input  logic                         i_ada_or,
   input  logic                         i_adb_or,
   output hc_pkg::tank_sample_t         o_sample
);

   localparam int W = `HC_ADC_W;

   // extremes of the two's complement word
   localparam logic signed [W-1:0] ADC_MIN = {1'b1, {(W-1){1'b0}}};
   localparam logic signed [W-1:0] ADC_MAX = {1'b0, {(W-1){1'b1}}};

   // negate, most negative code clamps to full scale
   // plain negation would wrap it back negative
   function automatic logic signed [W-1:0] neg_sat(input logic signed [W-1:0] x);
      logic signed [W-1:0] r;
      if (x == ADC_MIN) begin
         r = ADC_MAX;
      end else begin
         r = -x;
      end
      return r;
   endfunction

   // ========================================
   // capture register
   // ========================================

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_sample.valid <= 1'b0;
      end else begin
         // clipped data must never reach the law
         o_sample.valid <= ~(i_ada_or | i_adb_or);
      end
      // payload follows the pins every edge
      // channel A carries vC, channel B carries iC
      o_sample.vc <= neg_sat(i_ada_data);
      o_sample.ic <= neg_sat(i_adb_data);
   end

endmodule

// File: hc_pkg.sv
// hybrid control shared types: tank sample, bridge gate pattern and state enums
`include "hc_params.svh"

package hc_pkg;

   // ========================================
   // datapath structs
   // ========================================

   // one tank sample pair, valid low when either ADC clipped
   typedef struct packed {
      logic                         valid;
      // capacitor voltage, channel A
      logic signed [`HC_ADC_W-1:0]  vc;
      // inductor current, channel B
      logic signed [`HC_ADC_W-1:0]  ic;
   } tank_sample_t;

   // bridge gates, m1 lands on bit 0
   // leg 1 is m1 high / m3 low
   // leg 2 is m2 high / m4 low
   typedef struct packed {
      logic m4;
      logic m3;
      logic m2;
      logic m1;
   } gate_t;

   // ========================================
   // state encodings
   // ========================================

   // bridge state of the hybrid law
   // pos drives m1+m4, neg drives m2+m3
   typedef enum logic {
      SIGMA_POS = 1'b0,
      SIGMA_NEG = 1'b1
   } sigma_e;

   // supervisor start-up sequence
   typedef enum logic [1:0] {
      SUP_IDLE   = 2'd0,
      SUP_BOOT   = 2'd1,
      SUP_PRESET = 2'd2,
      SUP_RUN    = 2'd3
   } sup_state_e;

endpackage

// File: hc_params.svh
// hybrid control constants: sample widths, start-up phase lengths, dead-time table, phi scale
`ifndef HC_PARAMS_SVH
`define HC_PARAMS_SVH

// ========================================
// tank ADC and setpoints
// ========================================

// tank ADC word width, two's complement
`define HC_ADC_W 14

// phi and delta setpoint width
`define HC_SET_W 8

// phi to vC threshold, ADC counts per phi step
`define HC_PHI_SCALE 64

// ========================================
// start-up sequence
// ========================================

// low sides on, bootstrap caps charging
`define HC_BOOT_CYCLES 40

// sigma forced positive to pre-charge the tank
`define HC_PRESET_CYCLES 16

// ========================================
// dead-time table, cycles per i_dt_sel code
// ========================================

`define HC_DT0 8
`define HC_DT1 2
`define HC_DT2 4
`define HC_DT3 6

// counter must hold the largest entry
`define HC_DT_MAX_W 4

`endif
